// ==== compile.f ====
+incdir+source
+incdir+test
source/gqa_pkg.sv
source/matmul.sv
source/softermax.sv
source/gqa_head.sv
source/gqa_group.sv
test/tb_gqa_group.sv

// ==== Makefile ====
# Verilator build and run of the grouped-query attention testbench
# Variables can be overridden on the command line, for example make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_gqa_group
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_TEXT := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/gqa_model.svh ====
`ifndef GQA_MODEL_SVH
`define GQA_MODEL_SVH

// Clamp to a signed range of the given width
function automatic longint saturate(input longint value, input int width);
    longint hi;
    longint lo;
    hi = (longint'(1) << (width - 1)) - 1;
    lo = -(longint'(1) << (width - 1));
    if (value > hi)
        return hi;
    if (value < lo)
        return lo;
    return value;
endfunction

function automatic proj_mat_t project(
    input act_t [`GQA_SEQ_DIM-1:0][`GQA_EMB_DIM-1:0]  act,
    input act_t [`GQA_EMB_DIM-1:0][`GQA_HEAD_DIM-1:0] weight
);
    proj_mat_t result;
    longint    acc;
    for (int r = 0; r < `GQA_SEQ_DIM; r++) begin
        for (int c = 0; c < `GQA_HEAD_DIM; c++) begin
            acc = 0;
            for (int e = 0; e < `GQA_EMB_DIM; e++)
                acc += longint'(act[r][e]) * longint'(weight[e][c]);
            acc = acc >>> (2 * `GQA_ACT_FRAC - `GQA_PROJ_FRAC);
            result[r][c] = proj_t'(saturate(acc, `GQA_PROJ_W));
        end
    end
    return result;
endfunction

// S = Q K^T
function automatic score_mat_t score_product(input proj_mat_t q, input proj_mat_t k);
    score_mat_t result;
    longint     acc;
    for (int i = 0; i < `GQA_SEQ_DIM; i++) begin
        for (int j = 0; j < `GQA_SEQ_DIM; j++) begin
            acc = 0;
            for (int c = 0; c < `GQA_HEAD_DIM; c++)
                acc += longint'(q[i][c]) * longint'(k[j][c]);
            acc = acc >>> (2 * `GQA_PROJ_FRAC - `GQA_SCORE_FRAC);
            result[i][j] = score_t'(saturate(acc, `GQA_SCORE_W));
        end
    end
    return result;
endfunction

// Base-2 row normalization, 2^-d taken as (256 - 8 f) >> i
function automatic prob_mat_t softermax_rows(input score_mat_t s);
    prob_mat_t result;
    longint    pow[`GQA_SEQ_DIM];
    longint    top;
    longint    total;
    longint    d;
    longint    quot;
    for (int r = 0; r < `GQA_SEQ_DIM; r++) begin
        top = s[r][0];
        for (int c = 1; c < `GQA_SEQ_DIM; c++)
            if (s[r][c] > top)
                top = s[r][c];
        total = 0;
        for (int c = 0; c < `GQA_SEQ_DIM; c++) begin
            d = top - longint'(s[r][c]);
            pow[c] = (d / 16 > 9) ? 0 : (256 - 8 * (d % 16)) >> (d / 16);
            total += pow[c];
        end
        for (int c = 0; c < `GQA_SEQ_DIM; c++) begin
            quot = (pow[c] * 256) / total;
            result[r][c] = prob_t'((quot > 511) ? 511 : quot);
        end
    end
    return result;
endfunction

function automatic head_out_t weighted_values(input prob_mat_t p, input proj_mat_t v);
    head_out_t result;
    longint    acc;
    for (int r = 0; r < `GQA_SEQ_DIM; r++) begin
        for (int c = 0; c < `GQA_HEAD_DIM; c++) begin
            acc = 0;
            for (int k = 0; k < `GQA_SEQ_DIM; k++)
                acc += longint'(p[r][k]) * longint'(v[k][c]);
            acc = acc >>> (`GQA_PROB_FRAC + `GQA_PROJ_FRAC - `GQA_OUT_FRAC);
            result[r][c] = out_t'(saturate(acc, `GQA_OUT_W));
        end
    end
    return result;
endfunction

// Whole group for one input beat
function automatic gqa_out_t expected_group(input gqa_in_t beat);
    gqa_out_t  result;
    proj_mat_t k;
    proj_mat_t v;
    k = project(beat.act, beat.k_weight);
    v = project(beat.act, beat.v_weight);
    for (int g = 0; g < `GQA_GROUP_SIZE; g++)
        result.head[g] = weighted_values(
            softermax_rows(score_product(project(beat.act, beat.q_weight[g]), k)), v);
    return result;
endfunction

`endif

// ==== test/tb_gqa_group.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gqa_cfg.svh"

module tb_gqa_group
    import gqa_pkg::*;
();

    localparam int SEND_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 600;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    gqa_in_t  in_data;
    logic     out_valid;
    logic     out_ready;
    gqa_out_t out_data;

    integer   seed;
    int       mismatch_errors;
    int       timeout_errors;
    int       other_errors;

    // Expected results in input order
    gqa_out_t exp_q[$];
    bit       same_q[$];
    gqa_out_t exp_front;
    bit       exp_same;
    bit       exp_have;
    int       max_in_flight;
    int       blocked_run;
    int       longest_block;
    bit       random_ready;
    int       hold_low_cycles;

    gqa_group u_dut (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    `include "gqa_model.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // out_ready is picked 1 ns after the edge and driven at 2 ns
    initial begin
        bit next_ready;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (hold_low_cycles > 0) begin
                next_ready = 1'b0;
                hold_low_cycles--;
            end else if (random_ready) begin
                next_ready = (($random(seed) % 4) != 0);
            end else begin
                next_ready = 1'b1;
            end
            #1;
            out_ready = next_ready;
        end
    end

    // Transfers are known half a cycle ahead of the edge that takes them
    always @(negedge clk) begin
        if (!reset) begin
            blocked_run = (in_valid && !in_ready) ? blocked_run + 1 : 0;
            if (blocked_run > longest_block)
                longest_block = blocked_run;
            if (out_valid && out_ready) begin
                exp_have = (exp_q.size() > 0);
                if (exp_have) begin
                    exp_front = exp_q.pop_front();
                    exp_same  = same_q.pop_front();
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) out_valid && out_ready |-> exp_have)
    else begin
        other_errors++;
        $display("output transfer at %0t with no input beat outstanding", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && exp_have |-> out_data == exp_front)
    else begin
        mismatch_errors++;
        $display("mismatch at %0t: out_data %h, expected %h", $time, out_data, exp_front);
    end

    // Equal query weights give head 1 the expected result of head 0
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && exp_have && exp_same
        |-> out_data.head[1] == exp_front.head[0])
    else begin
        mismatch_errors++;
        $display("mismatch at %0t: head 1 output %h, expected head 0 result %h",
                 $time, out_data.head[1], exp_front.head[0]);
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        mismatch_errors++;
        $display("mismatch at %0t: output changed or dropped while out_ready was low", $time);
    end

    task automatic finish_run();
        $display("error counts: mismatch %0d, timeout %0d, other %0d",
                 mismatch_errors, timeout_errors, other_errors);
        if (mismatch_errors + timeout_errors + other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    function automatic gqa_in_t random_beat(input int span);
        logic [$bits(gqa_in_t)-1:0] flat;
        for (int i = 0; i < $bits(gqa_in_t) / `GQA_ACT_W; i++)
            flat[i*`GQA_ACT_W +: `GQA_ACT_W] = act_t'($random(seed) % span);
        return gqa_in_t'(flat);
    endfunction

    // Every element at the top or bottom of the range
    function automatic gqa_in_t extreme_beat();
        logic [$bits(gqa_in_t)-1:0] flat;
        for (int i = 0; i < $bits(gqa_in_t) / `GQA_ACT_W; i++)
            flat[i*`GQA_ACT_W +: `GQA_ACT_W] = ($random(seed) & 1) ? act_t'(127) : act_t'(-128);
        return gqa_in_t'(flat);
    endfunction

    // Called 2 ns after an edge and returns 2 ns after the accepting edge
    task automatic send_beat(input gqa_in_t beat, input bit same_heads);
        int waited;
        waited = 0;
        in_data  = beat;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > SEND_TIMEOUT) begin
                timeout_errors++;
                $display("timeout: in_ready stayed low for %0d cycles with a beat waiting", waited);
                finish_run();
            end
            @(negedge clk);
        end
        exp_q.push_back(expected_group(beat));
        same_q.push_back(same_heads);
        if (exp_q.size() > max_in_flight)
            max_in_flight = exp_q.size();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                timeout_errors++;
                $display("timeout: %0d expected outputs never arrived", exp_q.size());
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        gqa_in_t beat;
        seed            = 32'h0658_bbd6;
        mismatch_errors = 0;
        timeout_errors  = 0;
        other_errors    = 0;
        exp_front       = '0;
        exp_same        = 1'b0;
        exp_have        = 1'b0;
        max_in_flight   = 0;
        blocked_run     = 0;
        longest_block   = 0;
        random_ready    = 1'b0;
        hold_low_cycles = 0;
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_data         = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready)
        else begin
            other_errors++;
            $display("after reset out_valid is not low or in_ready is not high");
        end
        @(posedge clk);
        #2;

        // One beat at a time
        for (int i = 0; i < 6; i++) begin
            send_beat(random_beat(8), 1'b0);
            wait_drain();
        end

        // Back-to-back beats keep several items in flight
        for (int i = 0; i < 8; i++)
            send_beat(random_beat(8), 1'b0);
        wait_drain();
        assert (max_in_flight >= 2)
        else begin
            other_errors++;
            $display("never more than one beat in flight during back-to-back input");
        end

        // Long stall first and random out_ready after it
        random_ready    = 1'b1;
        hold_low_cycles = 120;
        for (int i = 0; i < 10; i++)
            send_beat(random_beat(8), 1'b0);
        wait_drain();
        random_ready = 1'b0;
        assert (longest_block >= 40)
        else begin
            other_errors++;
            $display("in_ready did not stay low while the output was stalled");
        end

        // Saturation
        for (int i = 0; i < 6; i++)
            send_beat(extreme_beat(), 1'b0);
        wait_drain();

        // Equal query weights in both heads over the shared K and V
        for (int i = 0; i < 4; i++) begin
            beat = random_beat(16);
            beat.q_weight[1] = beat.q_weight[0];
            send_beat(beat, 1'b1);
        end
        wait_drain();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== source/gqa_group.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gqa_cfg.svh"

module gqa_group
    import gqa_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    in_valid,
    output logic         in_ready,
    input  wire gqa_in_t in_data,
    output logic         out_valid,
    input  wire logic    out_ready,
    output gqa_out_t     out_data
);

    localparam int G = `GQA_GROUP_SIZE;

    logic            fork_valid;
    logic            k_in_ready, v_in_ready;
    logic [G-1:0]    q_ready;
    proj_mat_t       k_proj, v_proj;
    logic            k_out_valid, k_out_ready;
    logic            v_out_valid, v_out_ready;
    logic [G-1:0]    head_k_ready, head_v_ready;
    logic [G-1:0]    head_valid, head_ready;

    // Fork: every consumer takes the beat in the same cycle
    assign in_ready   = k_in_ready && v_in_ready && (&q_ready);
    assign fork_valid = in_valid && in_ready;

    // Shared K projection
    matmul #(
        .M(`GQA_SEQ_DIM), .K(`GQA_EMB_DIM), .N(`GQA_HEAD_DIM),
        .A_W(`GQA_ACT_W), .A_FRAC(`GQA_ACT_FRAC),
        .B_W(`GQA_ACT_W), .B_FRAC(`GQA_ACT_FRAC),
        .OUT_W(`GQA_PROJ_W), .OUT_FRAC(`GQA_PROJ_FRAC),
        .B_TRANSPOSED(1'b0)
    ) u_k_mm (
        .clk(clk), .reset(reset),
        .in_valid(fork_valid), .in_ready(k_in_ready),
        .a_data(in_data.act), .b_data(in_data.k_weight),
        .out_data(k_proj), .out_valid(k_out_valid), .out_ready(k_out_ready)
    );

    // Shared V projection
    matmul #(
        .M(`GQA_SEQ_DIM), .K(`GQA_EMB_DIM), .N(`GQA_HEAD_DIM),
        .A_W(`GQA_ACT_W), .A_FRAC(`GQA_ACT_FRAC),
        .B_W(`GQA_ACT_W), .B_FRAC(`GQA_ACT_FRAC),
        .OUT_W(`GQA_PROJ_W), .OUT_FRAC(`GQA_PROJ_FRAC),
        .B_TRANSPOSED(1'b0)
    ) u_v_mm (
        .clk(clk), .reset(reset),
        .in_valid(fork_valid), .in_ready(v_in_ready),
        .a_data(in_data.act), .b_data(in_data.v_weight),
        .out_data(v_proj), .out_valid(v_out_valid), .out_ready(v_out_ready)
    );

    // K and V go to all heads at once
    assign k_out_ready = &head_k_ready;
    assign v_out_ready = &head_v_ready;

    for (genvar g = 0; g < G; g++) begin : g_head
        gqa_head u_head (
            .clk(clk), .reset(reset),
            .q_valid(fork_valid), .q_ready(q_ready[g]),
            .q_act(in_data.act), .q_weight(in_data.q_weight[g]),
            .k_valid(k_out_valid && k_out_ready), .k_ready(head_k_ready[g]), .k_data(k_proj),
            .v_valid(v_out_valid && v_out_ready), .v_ready(head_v_ready[g]), .v_data(v_proj),
            .out_valid(head_valid[g]), .out_ready(head_ready[g]),
            .out_data(out_data.head[g])
        );

        // Join: a head leaves only together with the others
        assign head_ready[g] = out_ready && (&(head_valid | (G'(1) << g)));
    end

    assign out_valid = &head_valid;

    // Heads run in lockstep from the shared fork
    assert property (@(posedge clk) disable iff (reset)
        $rose(|head_valid) |-> &head_valid);

endmodule

`default_nettype wire

// ==== source/gqa_head.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gqa_cfg.svh"

module gqa_head
    import gqa_pkg::*;
(
    input  wire logic                                         clk,
    input  wire logic                                         reset,
    input  wire logic                                         q_valid,
    output logic                                              q_ready,
    input  wire act_t [`GQA_SEQ_DIM-1:0][`GQA_EMB_DIM-1:0]    q_act,
    input  wire act_t [`GQA_EMB_DIM-1:0][`GQA_HEAD_DIM-1:0]   q_weight,
    input  wire logic                                         k_valid,
    output logic                                              k_ready,
    input  wire proj_mat_t                                    k_data,
    input  wire logic                                         v_valid,
    output logic                                              v_ready,
    input  wire proj_mat_t                                    v_data,
    output logic                                              out_valid,
    input  wire logic                                         out_ready,
    output head_out_t                                         out_data
);

    proj_mat_t  q_proj;
    logic       q_out_valid, q_out_ready;
    score_mat_t scores;
    logic       score_in_valid, score_in_ready;
    logic       score_out_valid, score_out_ready;
    prob_mat_t  probs;
    logic       prob_valid, prob_ready;
    logic       val_in_valid, val_in_ready;

    matmul #(
        .M(`GQA_SEQ_DIM), .K(`GQA_EMB_DIM), .N(`GQA_HEAD_DIM),
        .A_W(`GQA_ACT_W), .A_FRAC(`GQA_ACT_FRAC),
        .B_W(`GQA_ACT_W), .B_FRAC(`GQA_ACT_FRAC),
        .OUT_W(`GQA_PROJ_W), .OUT_FRAC(`GQA_PROJ_FRAC),
        .B_TRANSPOSED(1'b0)
    ) u_q_mm (
        .clk(clk), .reset(reset),
        .in_valid(q_valid), .in_ready(q_ready),
        .a_data(q_act), .b_data(q_weight),
        .out_data(q_proj), .out_valid(q_out_valid), .out_ready(q_out_ready)
    );

    // Own Q meets the shared K
    assign k_ready        = score_in_ready && q_out_valid;
    assign q_out_ready    = score_in_ready && k_valid;
    assign score_in_valid = q_out_valid && k_valid;

    // K is read transposed, S = Q K^T
    matmul #(
        .M(`GQA_SEQ_DIM), .K(`GQA_HEAD_DIM), .N(`GQA_SEQ_DIM),
        .A_W(`GQA_PROJ_W), .A_FRAC(`GQA_PROJ_FRAC),
        .B_W(`GQA_PROJ_W), .B_FRAC(`GQA_PROJ_FRAC),
        .OUT_W(`GQA_SCORE_W), .OUT_FRAC(`GQA_SCORE_FRAC),
        .B_TRANSPOSED(1'b1)
    ) u_score_mm (
        .clk(clk), .reset(reset),
        .in_valid(score_in_valid), .in_ready(score_in_ready),
        .a_data(q_proj), .b_data(k_data),
        .out_data(scores), .out_valid(score_out_valid), .out_ready(score_out_ready)
    );

    softermax u_softermax (
        .clk(clk), .reset(reset),
        .in_valid(score_out_valid), .in_ready(score_out_ready), .in_data(scores),
        .out_valid(prob_valid), .out_ready(prob_ready), .out_data(probs)
    );

    // Probabilities meet the shared V
    assign v_ready      = val_in_ready && prob_valid;
    assign prob_ready   = val_in_ready && v_valid;
    assign val_in_valid = prob_valid && v_valid;

    matmul #(
        .M(`GQA_SEQ_DIM), .K(`GQA_SEQ_DIM), .N(`GQA_HEAD_DIM),
        .A_W(`GQA_PROB_W), .A_FRAC(`GQA_PROB_FRAC),
        .B_W(`GQA_PROJ_W), .B_FRAC(`GQA_PROJ_FRAC),
        .OUT_W(`GQA_OUT_W), .OUT_FRAC(`GQA_OUT_FRAC),
        .B_TRANSPOSED(1'b0)
    ) u_val_mm (
        .clk(clk), .reset(reset),
        .in_valid(val_in_valid), .in_ready(val_in_ready),
        .a_data(probs), .b_data(v_data),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    // Once a score item is taken, K is refused while it is computed
    assert property (@(posedge clk) disable iff (reset)
        score_in_valid && score_in_ready |=> !k_ready);

endmodule

`default_nettype wire

// ==== source/softermax.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gqa_cfg.svh"

module softermax
    import gqa_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       in_valid,
    output logic            in_ready,
    input  wire score_mat_t in_data,
    output logic            out_valid,
    input  wire logic       out_ready,
    output prob_mat_t       out_data
);

    localparam int SEQ         = `GQA_SEQ_DIM;
    localparam int ROW_W       = $clog2(SEQ + 1);
    localparam int IDX_W       = $clog2(SEQ);
    localparam int POW_W       = `GQA_PROB_FRAC + 1;
    localparam int SUM_W       = POW_W + $clog2(SEQ);
    localparam int SLOPE_SHIFT = `GQA_PROB_FRAC - `GQA_SCORE_FRAC - 1;
    localparam int PROB_MAX    = (1 << (`GQA_PROB_W - 1)) - 1;
    localparam logic [POW_W-1:0] ONE = POW_W'(1 << `GQA_PROB_FRAC);

    softermax_state_t               state;
    score_mat_t                     scores;
    logic [ROW_W-1:0]               row;
    logic [SEQ-1:0][POW_W-1:0]      pow_row;
    logic [SEQ-1:0][POW_W-1:0]      pow_reg;
    logic [SUM_W-1:0]               sum_row;
    logic [SUM_W-1:0]               sum_reg;
    prob_t [SEQ-1:0]                prob_row;

    assign in_ready  = (state == sm_idle);
    assign out_valid = (state == sm_hold);

    // Stage 1: row max and 2^-(m-x) with a linear fraction term
    always_comb begin
        score_t                       mx;
        score_t                       x;
        logic signed [`GQA_SCORE_W:0] d;
        logic [POW_W-1:0]             frac_ext;
        mx = scores[row[IDX_W-1:0]][0];
        for (int c = 1; c < SEQ; c++) begin
            x = scores[row[IDX_W-1:0]][c];
            if (x > mx)
                mx = x;
        end
        sum_row = '0;
        for (int c = 0; c < SEQ; c++) begin
            x = scores[row[IDX_W-1:0]][c];
            d = mx - x;
            frac_ext = POW_W'(d[`GQA_SCORE_FRAC-1:0]);
            pow_row[c] = (ONE - (frac_ext << SLOPE_SHIFT)) >> d[`GQA_SCORE_W:`GQA_SCORE_FRAC];
            sum_row = sum_row + SUM_W'(pow_row[c]);
        end
    end

    // Stage 2: normalize the previous row, sum is at least 1.0
    always_comb begin
        logic [POW_W+`GQA_PROB_FRAC-1:0] quot;
        for (int c = 0; c < SEQ; c++) begin
            quot = {pow_reg[c], {`GQA_PROB_FRAC{1'b0}}} / sum_reg;
            prob_row[c] = (quot > PROB_MAX) ? prob_t'(PROB_MAX) : prob_t'(quot);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sm_idle;
            row   <= '0;
        end else begin
            case (state)
                sm_idle: begin
                    if (in_valid) begin
                        state <= sm_run;
                        row   <= '0;
                    end
                end
                sm_run: begin
                    if (int'(row) == SEQ)
                        state <= sm_hold;
                    else
                        row <= row + 1'b1;
                end
                sm_hold: begin
                    if (out_ready)
                        state <= sm_idle;
                end
                default: state <= sm_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sm_idle && in_valid)
            scores <= in_data;
        if (state == sm_run) begin
            pow_reg <= pow_row;
            sum_reg <= sum_row;
            if (row != '0)
                out_data[IDX_W'(row - 1'b1)] <= prob_row;
        end
    end

    // No probability above 1.0
    for (genvar r = 0; r < SEQ; r++) begin : g_chk_row
        for (genvar c = 0; c < SEQ; c++) begin : g_chk_col
            assert property (@(posedge clk) disable iff (reset)
                out_valid |-> $signed(out_data[r][c]) <= 256);
        end
    end

endmodule

`default_nettype wire

// ==== source/matmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul #(
    parameter int M            = 4,
    parameter int K            = 8,
    parameter int N            = 4,
    parameter int A_W          = 8,
    parameter int A_FRAC       = 2,
    parameter int B_W          = 8,
    parameter int B_FRAC       = 2,
    parameter int OUT_W        = 16,
    parameter int OUT_FRAC     = 4,
    parameter bit B_TRANSPOSED = 1'b0
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire logic [M*K*A_W-1:0] a_data,
    input  wire logic [K*N*B_W-1:0] b_data,
    output logic [M*N*OUT_W-1:0]    out_data,
    output logic                    out_valid,
    input  wire logic               out_ready
);

    localparam int ACC_W = A_W + B_W + $clog2(K) + 1;
    localparam int SHIFT = A_FRAC + B_FRAC - OUT_FRAC;
    localparam int ROW_W = $clog2(M + 1);
    localparam logic signed [ACC_W-1:0] OUT_MAX = {{(ACC_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] OUT_MIN = {{(ACC_W-OUT_W+1){1'b1}}, {(OUT_W-1){1'b0}}};

    logic [M*K*A_W-1:0] a_reg;
    logic [K*N*B_W-1:0] b_reg;
    logic [ROW_W-1:0]   row;
    logic               busy;
    logic [N*OUT_W-1:0] row_result;

    // One item at a time, free again once the result has left
    assign in_ready = !busy && !out_valid;

    // Current row, N outputs of K parallel products each
    always_comb begin
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] scaled;
        logic signed [A_W-1:0]   a_el;
        logic signed [B_W-1:0]   b_el;
        int                      r;
        int                      b_idx;
        r = (int'(row) < M) ? int'(row) : 0;
        row_result = '0;
        for (int n = 0; n < N; n++) begin
            acc = '0;
            for (int k = 0; k < K; k++) begin
                // Transposed B is stored N by K
                b_idx = B_TRANSPOSED ? (n * K + k) : (k * N + n);
                a_el = a_reg[(r * K + k) * A_W +: A_W];
                b_el = b_reg[b_idx * B_W +: B_W];
                acc = acc + a_el * b_el;
            end
            scaled = acc >>> SHIFT;
            if (scaled > OUT_MAX)
                row_result[n*OUT_W +: OUT_W] = OUT_MAX[OUT_W-1:0];
            else if (scaled < OUT_MIN)
                row_result[n*OUT_W +: OUT_W] = OUT_MIN[OUT_W-1:0];
            else
                row_result[n*OUT_W +: OUT_W] = scaled[OUT_W-1:0];
        end
    end

    // Rows 0 to M-1, then one closing cycle before out_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            row       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                busy <= 1'b1;
                row  <= '0;
            end else if (busy) begin
                if (int'(row) == M) begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end
            if (out_valid && out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            a_reg <= a_data;
            b_reg <= b_data;
        end
        if (busy && (int'(row) < M))
            out_data[int'(row)*N*OUT_W +: N*OUT_W] <= row_result;
    end

    // Request must stay up until it is taken
    assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid);

    assert property (@(posedge clk) disable iff (reset) int'(row) <= M);

endmodule

`default_nettype wire

// ==== source/gqa_pkg.sv ====
`default_nettype none
`include "gqa_cfg.svh"

package gqa_pkg;

    // Fixed-point element types
    typedef logic signed [`GQA_ACT_W-1:0]   act_t;
    typedef logic signed [`GQA_PROJ_W-1:0]  proj_t;
    typedef logic signed [`GQA_SCORE_W-1:0] score_t;
    typedef logic signed [`GQA_PROB_W-1:0]  prob_t;
    typedef logic signed [`GQA_OUT_W-1:0]   out_t;

    // Row-major matrices, element [r][c] at the low end for r = c = 0
    typedef proj_t  [`GQA_SEQ_DIM-1:0][`GQA_HEAD_DIM-1:0] proj_mat_t;
    typedef score_t [`GQA_SEQ_DIM-1:0][`GQA_SEQ_DIM-1:0]  score_mat_t;
    typedef prob_t  [`GQA_SEQ_DIM-1:0][`GQA_SEQ_DIM-1:0]  prob_mat_t;
    typedef out_t   [`GQA_SEQ_DIM-1:0][`GQA_HEAD_DIM-1:0] head_out_t;

    // One input beat of the group
    typedef struct packed {
        act_t [`GQA_SEQ_DIM-1:0][`GQA_EMB_DIM-1:0] act;
        act_t [`GQA_GROUP_SIZE-1:0][`GQA_EMB_DIM-1:0][`GQA_HEAD_DIM-1:0] q_weight;
        act_t [`GQA_EMB_DIM-1:0][`GQA_HEAD_DIM-1:0] k_weight;
        act_t [`GQA_EMB_DIM-1:0][`GQA_HEAD_DIM-1:0] v_weight;
    } gqa_in_t;

    // All head outputs together
    typedef struct packed {
        head_out_t [`GQA_GROUP_SIZE-1:0] head;
    } gqa_out_t;

    typedef enum logic [1:0] {
        sm_idle,
        sm_run,
        sm_hold
    } softermax_state_t;

endpackage

`default_nettype wire

// ==== source/gqa_cfg.svh ====
`ifndef GQA_CFG_SVH
`define GQA_CFG_SVH

// Tile dimensions
`define GQA_SEQ_DIM      4
`define GQA_EMB_DIM      8
`define GQA_GROUP_SIZE   2
`define GQA_HEAD_DIM     (`GQA_EMB_DIM / `GQA_GROUP_SIZE)

// Activations and all weights
`define GQA_ACT_W        8
`define GQA_ACT_FRAC     2

// Projected Q, K and V
`define GQA_PROJ_W       16
`define GQA_PROJ_FRAC    4

// Q times K transposed
`define GQA_SCORE_W      16
`define GQA_SCORE_FRAC   4

// Softermax output, 1.0 is 256
`define GQA_PROB_W       10
`define GQA_PROB_FRAC    8

// Group output
`define GQA_OUT_W        8
`define GQA_OUT_FRAC     2

`endif
